//--- Bender.yml
package:
  name: int_div_unit

sources:
  # Shared types first, then the stages, then the top level
  - design/divPkg.sv
  - design/divOperandPrep.sv
  - design/divStep.sv
  - design/divIterate.sv
  - design/divSignFix.sv
  - design/intDivUnit.sv

  # Testbench
  - target: simulation
    files:
      - bench/intDivTb.sv

//--- all.f
design/divPkg.sv
design/divOperandPrep.sv
design/divStep.sv
design/divIterate.sv
design/divSignFix.sv
design/intDivUnit.sv
bench/intDivTb.sv

//--- bench/intDivTb.sv
/*
  Integer divider testbench
  Table-driven stimulus with random output back-pressure and in-order result checks
*/
`timescale 1ns/10ps
`default_nettype none

module intDivTb;

  localparam int dataWidth    = 32;
  localparam int bitsPerCycle = 2;
  localparam int waitLimit    = 200;  // Cycles allowed per wait loop
  localparam int nRandom      = 40;

  logic                 clk;
  logic                 rstN;
  logic                 inValid;
  logic                 inReady;
  divPkg::divOp         inOp;
  logic [dataWidth-1:0] inA;
  logic [dataWidth-1:0] inB;
  logic                 outValid;
  logic                 outReady;
  logic [dataWidth-1:0] outResult;

  // One entry per table row
  divPkg::divOp         opQ  [$];
  logic [dataWidth-1:0] aQ   [$];
  logic [dataWidth-1:0] bQ   [$];
  logic [dataWidth-1:0] expQ [$];

  integer seed = 55;
  int     errCount = 0;
  int     checkCount = 0;

  intDivUnit #(
    .dataWidth   (dataWidth),
    .bitsPerCycle(bitsPerCycle)
  ) intDivUnit_inst (.*);

  always #20 clk = ~clk;  // 40 ns period

  ////////////////////////////////////////////////////////////
  // Reference model, checks and table
  ////////////////////////////////////////////////////////////

  // Truncates toward zero after the special cases
  function automatic logic [31:0] refResult(divPkg::divOp op, logic [31:0] a, logic [31:0] b);
    logic        isRem;
    logic        isSigned;
    logic [31:0] q;
    logic [31:0] r;
    isRem    = (op == divPkg::opRem) || (op == divPkg::opRemu);
    isSigned = (op == divPkg::opDiv) || (op == divPkg::opRem);
    if (b == '0) begin
      q = '1;  // Divide by zero
      r = a;
    end else if (isSigned && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      q = a;   // Overflow wraps
      r = '0;
    end else if (isSigned) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return isRem ? r : q;
  endfunction

  task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic abortRun(input string why);
    $display("Run stopped: %s", why);
    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    $display("TB FAILED");
    $finish;
  endtask

  task automatic addRow(input divPkg::divOp op, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] exp);
    opQ.push_back(op);
    aQ.push_back(a);
    bQ.push_back(b);
    expQ.push_back(exp);
  endtask

  task automatic buildTable();
    logic [1:0]  opBits;
    logic [31:0] a;
    logic [31:0] b;
    int          pick;
    // Unsigned
    addRow(divPkg::opDivu, 32'd100, 32'd7, 32'd14);
    addRow(divPkg::opRemu, 32'd100, 32'd7, 32'd2);
    addRow(divPkg::opDivu, 32'hffff_ffff, 32'd1, 32'hffff_ffff);
    addRow(divPkg::opDivu, 32'hffff_ffff, 32'd10, 32'h1999_9999);
    addRow(divPkg::opRemu, 32'hffff_ffff, 32'd10, 32'd5);
    addRow(divPkg::opDivu, 32'd3, 32'd5, 32'd0);
    addRow(divPkg::opRemu, 32'd3, 32'd5, 32'd3);
    // Signed rows over all four sign combinations of 7 and 2
    addRow(divPkg::opDiv, 32'd7, 32'd2, 32'd3);
    addRow(divPkg::opRem, 32'd7, 32'd2, 32'd1);
    addRow(divPkg::opDiv, 32'hffff_fff9, 32'd2, 32'hffff_fffd);
    addRow(divPkg::opRem, 32'hffff_fff9, 32'd2, 32'hffff_ffff);
    addRow(divPkg::opDiv, 32'd7, 32'hffff_fffe, 32'hffff_fffd);
    addRow(divPkg::opRem, 32'd7, 32'hffff_fffe, 32'd1);
    addRow(divPkg::opDiv, 32'hffff_fff9, 32'hffff_fffe, 32'd3);
    addRow(divPkg::opRem, 32'hffff_fff9, 32'hffff_fffe, 32'hffff_ffff);
    addRow(divPkg::opDiv, 32'd0, 32'd5, 32'd0);
    // Zero divisor
    addRow(divPkg::opDiv, 32'd1234, 32'd0, 32'hffff_ffff);
    addRow(divPkg::opDivu, 32'd1234, 32'd0, 32'hffff_ffff);
    addRow(divPkg::opRem, 32'hffff_fffb, 32'd0, 32'hffff_fffb);
    addRow(divPkg::opRemu, 32'hdead_beef, 32'd0, 32'hdead_beef);
    // Most negative by minus one
    addRow(divPkg::opDiv, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
    addRow(divPkg::opRem, 32'h8000_0000, 32'hffff_ffff, 32'd0);
    addRow(divPkg::opDivu, 32'h8000_0000, 32'hffff_ffff, 32'd0);
    addRow(divPkg::opRemu, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
    for (int i = 0; i < nRandom; i++) begin
      opBits = 2'($random(seed));
      a      = $random(seed);
      b      = $random(seed);
      pick   = $random(seed) & 7;
      if (pick == 0) b = '0;                                 // Some zero divisors
      else if (pick < 4) b = {{24{b[31]}}, b[7:0]};          // Small signed divisors
      addRow(divPkg::divOp'(opBits), a, b, refResult(divPkg::divOp'(opBits), a, b));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Driver and monitor
  ////////////////////////////////////////////////////////////

  // Starts on a falling edge and ends one falling edge after the last transfer
  task automatic driveRows();
    int waitCnt;
    for (int i = 0; i < opQ.size(); i++) begin
      inValid = 1'b1;
      inOp    = opQ[i];
      inA     = aQ[i];
      inB     = bQ[i];
      waitCnt = 0;
      while (!inReady) begin           // Stable at the falling edge
        @(negedge clk);
        waitCnt++;
        if (waitCnt > waitLimit) abortRun($sformatf("inReady never rose for row %0d", i));
      end
      @(negedge clk);                  // Transfer happened on the rising edge
    end
    inValid = 1'b0;
  endtask

  task automatic collectResults();
    int idx;
    int waitCnt;
    idx     = 0;
    waitCnt = 0;
    while (idx < opQ.size()) begin
      @(negedge clk);
      outReady = ($random(seed) & 3) != 0;  // Ready about 3 cycles in 4
      if (outValid && outReady) begin
        checkValue(outResult, expQ[idx], $sformatf("row %0d %s %h %h",
                   idx, opQ[idx].name(), aQ[idx], bQ[idx]));
        idx++;
        waitCnt = 0;
      end else begin
        waitCnt++;
        if (waitCnt > waitLimit) abortRun($sformatf("no result for row %0d", idx));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clk      = 1'b0;
    rstN     = 1'b0;
    inValid  = 1'b0;
    inOp     = divPkg::opDiv;
    inA      = '0;
    inB      = '0;
    outReady = 1'b0;
    buildTable();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    // Nothing accepted yet, so no result may appear
    repeat (4) begin
      @(negedge clk);
      checkValue(outValid, 1'b0, "outValid high before any input");
      checkValue(inReady, 1'b1, "inReady low after reset");
    end
    fork
      driveRows();
      collectResults();
    join
    // Every row gave one result, so the pipe must now stay empty
    outReady = 1'b1;
    repeat (40) begin
      @(negedge clk);
      checkValue(outValid, 1'b0, "extra result after last row");
    end
    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/divIterate.sv
/*
  Divider iteration stage
  FSM sequencing restoring steps, bitsPerCycle quotient bits per clock
*/
`timescale 1ns/10ps
`default_nettype none

module divIterate #(
  parameter int dataWidth    = 32,
  parameter int bitsPerCycle = 2
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 prepValid,
  output logic                 prepReady,
  input  divPkg::divOp         prepOp,
  input  logic [dataWidth-1:0] prepAbsA,
  input  logic [dataWidth-1:0] prepAbsB,
  input  logic                 prepNegQ,
  input  logic                 prepNegR,
  input  logic                 prepDiv0,
  input  logic [dataWidth-1:0] prepA,
  output logic                 iterValid,
  input  logic                 iterReady,
  output logic [dataWidth-1:0] iterQuot,   // Unsigned quotient magnitude
  output logic [dataWidth-1:0] iterRem,    // Unsigned remainder magnitude
  output divPkg::divOp         iterOp,
  output logic                 iterNegQ,
  output logic                 iterNegR,
  output logic                 iterDiv0,
  output logic [dataWidth-1:0] iterA
);

  localparam int nSteps = dataWidth / bitsPerCycle;               // Busy cycles per op
  localparam int cntW   = (nSteps > 1) ? $clog2(nSteps) : 1;

  typedef enum logic [1:0] {idle, busy, done} iterState;

  iterState             state;
  logic [cntW-1:0]      stepCnt;      // Busy cycles elapsed
  logic                 accept;
  logic [dataWidth-1:0] wReg;         // Residual
  logic [dataWidth-1:0] xqReg;        // Shrinking dividend / growing quotient
  logic [dataWidth-1:0] divisorReg;   // Constant during an op
  logic [dataWidth-1:0] wChain  [bitsPerCycle+1];
  logic [dataWidth-1:0] xqChain [bitsPerCycle+1];

  assign prepReady = (state == idle);
  assign accept    = prepValid & prepReady;
  assign iterValid = (state == done);

  ////////////////////////////////////////////////////////////
  // Step chain
  ////////////////////////////////////////////////////////////

  assign wChain[0]  = wReg;
  assign xqChain[0] = xqReg;

  for (genvar i = 0; i < bitsPerCycle; i++) begin : gStep
    divStep #(
      .dataWidth(dataWidth)
    ) divStep_inst (
      .wIn    (wChain[i]),
      .xqIn   (xqChain[i]),
      .divisor(divisorReg),
      .wOut   (wChain[i+1]),
      .xqOut  (xqChain[i+1])
    );
  end

  ////////////////////////////////////////////////////////////
  // Datapath registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      wReg       <= '0;                           // Residual starts empty
      xqReg      <= prepAbsA;
      divisorReg <= prepAbsB;
      iterOp     <= prepOp;
      iterNegQ   <= prepNegQ;
      iterNegR   <= prepNegR;
      iterDiv0   <= prepDiv0;
      iterA      <= prepA;
    end else if (state == busy) begin
      wReg  <= wChain[bitsPerCycle];              // Advance by bitsPerCycle bits
      xqReg <= xqChain[bitsPerCycle];
    end
  end

  assign iterQuot = xqReg;
  assign iterRem  = wReg;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state   <= idle;
      stepCnt <= '0;
    end else begin
      case (state)
        idle: if (accept) begin
          stepCnt <= '0;
          state   <= prepDiv0 ? done : busy;      // Zero divisor skips iterations
        end
        busy: begin
          stepCnt <= stepCnt + 1'b1;
          if (stepCnt == cntW'(nSteps - 1)) state <= done;
        end
        done: if (iterReady) state <= idle;       // Hold under back-pressure
        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/divOperandPrep.sv
/*
  Divider operand preparation stage
  Takes operand signs and magnitudes and flags a zero divisor, one register deep
*/
`timescale 1ns/10ps
`default_nettype none

module divOperandPrep #(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 inValid,
  output logic                 inReady,
  input  divPkg::divOp         inOp,
  input  logic [dataWidth-1:0] inA,       // Dividend
  input  logic [dataWidth-1:0] inB,       // Divisor
  output logic                 prepValid,
  input  logic                 prepReady,
  output divPkg::divOp         prepOp,
  output logic [dataWidth-1:0] prepAbsA,  // |A|, or raw A on divide by zero
  output logic [dataWidth-1:0] prepAbsB,  // |B|
  output logic                 prepNegQ,  // Quotient needs negation
  output logic                 prepNegR,  // Remainder needs negation
  output logic                 prepDiv0,  // Divisor is zero
  output logic [dataWidth-1:0] prepA      // Raw dividend
);

  logic                 isSigned;  // Signed opcode
  logic                 signA;     // Effective dividend sign
  logic                 signB;     // Effective divisor sign
  logic                 div0;
  logic [dataWidth-1:0] absA;
  logic [dataWidth-1:0] absB;
  logic                 accept;    // Input transfer this cycle

  ////////////////////////////////////////////////////////////
  // Sign and magnitude
  ////////////////////////////////////////////////////////////

  assign isSigned = ~inOp[0];                      // opDiv and opRem
  assign signA    = isSigned & inA[dataWidth-1];
  assign signB    = isSigned & inB[dataWidth-1];
  assign div0     = (inB == '0);

  // Dividend magnitude, kept untouched when the divisor is zero
  assign absA = div0  ? inA : (signA ? -inA : inA);
  assign absB = signB ? -inB : inB;                // Most negative value wraps to itself

  ////////////////////////////////////////////////////////////
  // Handshake and stage register
  ////////////////////////////////////////////////////////////

  // Empty stage, or the next stage drains us this cycle
  assign inReady = ~prepValid | prepReady;
  assign accept  = inValid & inReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      prepValid <= 1'b0;
    end else if (inReady) begin
      prepValid <= inValid;                        // Load new op or go empty
    end
  end

  // Payload only moves on a transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      prepOp   <= inOp;
      prepAbsA <= absA;
      prepAbsB <= absB;
      prepNegQ <= signA ^ signB;
      prepNegR <= signA;                           // Remainder follows dividend
      prepDiv0 <= div0;
      prepA    <= inA;
    end
  end

endmodule

`default_nettype wire

//--- design/divPkg.sv
/*
  Integer divider shared types
  Opcode encoding and result selection used across the divider stages
*/
`default_nettype none

package divPkg;

  ////////////////////////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////////////////////////

  // Bit 0 set means unsigned, bit 1 set means remainder
  typedef enum logic [1:0] {
    opDiv  = 2'b00,  // Signed quotient
    opDivu = 2'b01,  // Unsigned quotient
    opRem  = 2'b10,  // Signed remainder
    opRemu = 2'b11   // Unsigned remainder
  } divOp;

  // Which corrected value leaves the output stage
  typedef enum logic {
    resQuot = 1'b0,  // Quotient path
    resRem  = 1'b1   // Remainder path
  } divResSel;

endpackage

`default_nettype wire

//--- design/divSignFix.sv
/*
  Divider output stage
  Sign correction, divide-by-zero results and quotient/remainder select, one register deep
*/
`timescale 1ns/10ps
`default_nettype none

module divSignFix #(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 iterValid,
  output logic                 iterReady,
  input  logic [dataWidth-1:0] iterQuot,
  input  logic [dataWidth-1:0] iterRem,
  input  divPkg::divOp         iterOp,
  input  logic                 iterNegQ,
  input  logic                 iterNegR,
  input  logic                 iterDiv0,
  input  logic [dataWidth-1:0] iterA,
  output logic                 outValid,
  input  logic                 outReady,
  output logic [dataWidth-1:0] outResult
);

  logic [dataWidth-1:0] quot;     // Final quotient
  logic [dataWidth-1:0] rem;      // Final remainder
  logic [dataWidth-1:0] result;
  divPkg::divResSel     resSel;
  logic                 accept;

  ////////////////////////////////////////////////////////////
  // Result correction
  ////////////////////////////////////////////////////////////

  // Overflow case falls out of the magnitude path on its own
  assign quot = iterDiv0 ? '1    : (iterNegQ ? -iterQuot : iterQuot);
  assign rem  = iterDiv0 ? iterA : (iterNegR ? -iterRem  : iterRem);

  // Opcode bit 1 picks remainder
  assign resSel = iterOp[1] ? divPkg::resRem : divPkg::resQuot;
  assign result = (resSel == divPkg::resRem) ? rem : quot;

  ////////////////////////////////////////////////////////////
  // Handshake and output register
  ////////////////////////////////////////////////////////////

  assign iterReady = ~outValid | outReady;
  assign accept    = iterValid & iterReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else if (iterReady) begin
      outValid <= iterValid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) outResult <= result;  // Held while outReady is low
  end

endmodule

`default_nettype wire

//--- design/divStep.sv
/*
  One restoring division step: shift, trial subtract, restore
*/
`timescale 1ns/10ps
`default_nettype none

module divStep #(
  parameter int dataWidth = 32
) (
  input  logic [dataWidth-1:0] wIn,      // Partial residual
  input  logic [dataWidth-1:0] xqIn,     // Dividend bits above, quotient bits below
  input  logic [dataWidth-1:0] divisor,
  output logic [dataWidth-1:0] wOut,
  output logic [dataWidth-1:0] xqOut
);

  logic [dataWidth:0] wShift;  // Residual with next dividend bit appended
  logic [dataWidth:0] diff;    // Trial difference, top bit is the sign
  logic               qBit;

  assign wShift = {wIn, xqIn[dataWidth-1]};
  assign diff   = wShift - {1'b0, divisor};
  assign qBit   = ~diff[dataWidth];                               // Non-negative keeps it
  assign wOut   = qBit ? diff[dataWidth-1:0] : wShift[dataWidth-1:0];  // Restore
  assign xqOut  = {xqIn[dataWidth-2:0], qBit};

endmodule

`default_nettype wire

//--- design/intDivUnit.sv
/*
  Pipelined restoring integer divider, RISC-V div/divu/rem/remu
*/
`timescale 1ns/10ps
`default_nettype none

module intDivUnit #(
  parameter int dataWidth    = 32,
  parameter int bitsPerCycle = 2   // 1, 2 or 4
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 inValid,
  output logic                 inReady,
  input  divPkg::divOp         inOp,
  input  logic [dataWidth-1:0] inA,
  input  logic [dataWidth-1:0] inB,
  output logic                 outValid,
  input  logic                 outReady,
  output logic [dataWidth-1:0] outResult
);

  // Prep to iterate
  logic                 prepValid, prepReady, prepNegQ, prepNegR, prepDiv0;
  divPkg::divOp         prepOp;
  logic [dataWidth-1:0] prepAbsA, prepAbsB, prepA;
  // Iterate to sign fix
  logic                 iterValid, iterReady, iterNegQ, iterNegR, iterDiv0;
  divPkg::divOp         iterOp;
  logic [dataWidth-1:0] iterQuot, iterRem, iterA;

  divOperandPrep #(.dataWidth(dataWidth)) divOperandPrep_inst (.*);

  divIterate #(
    .dataWidth   (dataWidth),
    .bitsPerCycle(bitsPerCycle)
  ) divIterate_inst (.*);

  divSignFix #(.dataWidth(dataWidth)) divSignFix_inst (.*);

endmodule

`default_nettype wire
